// File: project.f
+incdir+include
verilog/videoPkg.sv
verilog/rasterIf.sv
verilog/videoTiming.sv
verilog/bgScanline.sv
verilog/planeMixer.sv
verilog/colorPalette.sv
verilog/videoTop.sv
tb/videoTb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module videoTb -f project.f

simOut=$(./obj_dir/VvideoTb || true)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx 'Result: PASSED'; then
	exit 0
else
	exit 1
fi

// File: include/videoModel.svh
// Video stage reference model
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

	int unsigned       modelH;
	int unsigned       modelV;
	videoPkg::chrAddr  modelChr;    // Stage 1 ROM address
	logic [4:0]        modelAttr;   // Stage 1 priority and colour
	videoPkg::bgPixel  modelPix;    // Stage 2 pixel
	videoPkg::palEntry modelPal [videoPkg::palDepth];
	videoPkg::palEntry modelRead;
	logic [2:0]        modelBlank;

	function automatic void clearModel();
		modelH = 0;
		modelV = 0;
		modelChr = '0;
		modelAttr = '0;
		modelPix = '0;
		modelRead = '0;
		modelBlank = '0;
		foreach (modelPal[i])
			modelPal[i] = '0;
	endfunction

	function automatic videoPkg::rasterPos scrolledCol();
		return videoPkg::rasterPos'(modelH) + videoPkg::bgHOffset;
	endfunction

	function automatic videoPkg::rasterPos scrolledRow();
		return videoPkg::rasterPos'(modelV) + videoPkg::bgVOffset;
	endfunction

	function automatic videoPkg::vramAddr tileAddress();
		videoPkg::rasterPos ph;
		videoPkg::rasterPos pv;
		ph = scrolledCol();
		pv = scrolledRow();
		return {pv[7:3], ph[7:3]};
	endfunction

	function automatic videoPkg::chrAddr romAddress();
		return modelChr;
	endfunction

	function automatic logic hSyncWindow();
		return (modelH >= videoPkg::hSyncStart) && (modelH < videoPkg::hSyncEnd);
	endfunction

	function automatic logic vSyncWindow();
		return (modelV >= videoPkg::vSyncStart) && (modelV < videoPkg::vSyncEnd);
	endfunction

	function automatic videoPkg::rgb12 pixelColour();
		if (modelBlank[2])
			return '0;
		return {modelRead[7:6], modelRead[1:0], modelRead[5:4], modelRead[1:0],
			modelRead[3:2], modelRead[1:0]};
	endfunction

	// One rising edge, with this cycle's memory data and CPU inputs
	function automatic void advanceModel(videoPkg::vramWord vd, videoPkg::chrWord cd,
		videoPkg::pen sp, logic we, videoPkg::palIndex wa, videoPkg::palEntry wd);
		videoPkg::rasterPos ph;
		videoPkg::rasterPos pv;
		videoPkg::pen       nib;
		videoPkg::palIndex  idx;
		ph = scrolledCol();
		pv = scrolledRow();
		case (ph[2:0])
			3'd1: nib = cd[7:4];
			3'd2: nib = cd[3:0];
			3'd3: nib = cd[15:12];
			3'd4: nib = cd[11:8];
			3'd5: nib = cd[23:20];
			3'd6: nib = cd[19:16];
			3'd7: nib = cd[31:28];
			default: nib = cd[27:24];
		endcase
		if (modelPix[4] && modelPix[3:0] != 4'd0)
			idx = {1'b1, modelPix[3:0]};
		else if (sp != 4'd0)
			idx = {1'b0, sp};
		else
			idx = {1'b1, modelPix[3:0]};
		modelRead = modelPal[idx];
		if (we)
			modelPal[wa] = wd;
		modelBlank = {modelBlank[1:0],
			(modelH >= videoPkg::hVisible) || (modelV >= videoPkg::vVisible)};
		modelPix = {modelAttr[4], (nib == 4'd1) ? modelAttr[3:0] : nib};
		modelChr = {vd[10:0], pv[2:0]};
		modelAttr = {vd[11], vd[15:12]};
		modelH = (modelH == videoPkg::hTotal - 1) ? 0 : modelH + 1;
		if (modelH == 0)
			modelV = (modelV == videoPkg::vTotal - 1) ? 0 : modelV + 1;
	endfunction

`endif

// File: tb/videoTb.sv
// Video output stage testbench
`timescale 1ns/1ps
`default_nettype none

module videoTb
	import videoPkg::*;
;
	localparam int unsigned randSeed    = 32'h97fa_5590;
	localparam int          clkPeriod   = 20;
	localparam int          driveDelay  = 2;
	localparam int          resetCycles = 10;
	localparam int          frameRuns   = 2;
	localparam int          frameLimit  = 384 * 264 + 100;  // One frame plus slack

	logic              VCLK;
	logic              rstN;
	pen                spPixel;
	logic              palWe;
	palIndex           palWrAddr;
	palEntry           palWrData;
	vramWord           vramData;
	chrWord            chrData;
	videoPkg::vramAddr vramAddrOut;
	videoPkg::chrAddr  chrAddrOut;
	logic              hSync;
	logic              vSync;
	rgb12              rgb;

	vramWord    vram [1024];   // Tile map, answers in the same cycle
	chrWord     rom  [16384];  // Character ROM
	int         frameCount;
	int         writesDone;

`include "videoModel.svh"

	assign vramData = vram[vramAddrOut];
	assign chrData  = rom[chrAddrOut];

	videoTop uut (
		.VCLK     (VCLK),
		.rstN     (rstN),
		.spPixel  (spPixel),
		.palWe    (palWe),
		.palWrAddr(palWrAddr),
		.palWrData(palWrData),
		.vramData (vramData),
		.chrData  (chrData),
		.vramAddr (vramAddrOut),
		.chrAddr  (chrAddrOut),
		.hSync    (hSync),
		.vSync    (vSync),
		.rgb      (rgb)
	);

	initial begin
		VCLK = 1'b0;
		forever #(clkPeriod / 2) VCLK = ~VCLK;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "Output mismatch");
		end
	endtask

	// New sprite pen each cycle, palette loads then writes in active video
	task automatic driveInputs();
		spPixel = (($urandom % 4) == 0) ? 4'd0 : pen'($urandom);
		if (writesDone < palDepth) begin
			palWe     = 1'b1;
			palWrAddr = palIndex'(writesDone);
			palWrData = palEntry'($urandom);
			writesDone++;
		end else if (modelH < hVisible && modelV < vVisible && ($urandom % 8) == 0) begin
			palWe     = 1'b1;
			palWrAddr = palIndex'($urandom);
			palWrData = palEntry'($urandom);
		end else begin
			palWe = 1'b0;
		end
	endtask

	task automatic checkCycle();
		checkValue("hSync", 32'(hSync), 32'(hSyncWindow()));
		checkValue("vSync", 32'(vSync), 32'(vSyncWindow()));
		checkValue("vramAddr", 32'(vramAddrOut), 32'(tileAddress()));
		checkValue("chrAddr", 32'(chrAddrOut), 32'(romAddress()));
		checkValue("rgb", 32'(rgb), 32'(pixelColour()));
		// Memory data indexed by the predicted addresses
		advanceModel(vram[tileAddress()], rom[romAddress()], spPixel,
			palWe, palWrAddr, palWrData);
		if (modelH == 0 && modelV == 0)
			frameCount++;
	endtask

	task automatic runCycle();
		driveInputs();
		@(negedge VCLK);
		checkCycle();
		@(posedge VCLK);
		#(driveDelay);
	endtask

	task automatic waitFrame();
		int count;
		int startFrames;
		count       = 0;
		startFrames = frameCount;
		while (frameCount == startFrames) begin
			if (count >= frameLimit) begin
				$display("Timed out waiting for the next frame boundary");
				$display("Result: FAILED");
				$fatal(1, "Frame timeout");
			end
			runCycle();
			count++;
		end
	endtask

	initial begin
		void'($urandom(randSeed));
		rstN       = 1'b0;
		spPixel    = '0;
		palWe      = 1'b0;
		palWrAddr  = '0;
		palWrData  = '0;
		frameCount = 0;
		writesDone = 0;
		for (int a = 0; a < 1024; a++)
			vram[a] = vramWord'($urandom);
		for (int a = 0; a < 16384; a++)
			rom[a] = chrWord'($urandom);
		clearModel();

		repeat (resetCycles - 1) @(posedge VCLK);
		@(negedge VCLK);
		checkValue("hSync", 32'(hSync), 32'd0);  // Quiet outputs in reset
		checkValue("vSync", 32'(vSync), 32'd0);
		checkValue("rgb", 32'(rgb), 32'd0);
		@(posedge VCLK);
		#(driveDelay);
		rstN = 1'b1;

		for (int f = 0; f < frameRuns; f++)
			waitFrame();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/videoTop.sv
// Video output stage top level
`timescale 1ns/1ps
`default_nettype none

module videoTop
	import videoPkg::*;
(
	input  logic             VCLK,
	input  logic             rstN,
	input  pen               spPixel,    // From the sprite line buffer
	input  logic             palWe,
	input  palIndex          palWrAddr,
	input  palEntry          palWrData,
	input  vramWord          vramData,
	input  chrWord           chrData,
	output videoPkg::vramAddr vramAddr,
	output videoPkg::chrAddr  chrAddr,
	output logic             hSync,
	output logic             vSync,
	output rgb12             rgb
);

	bgPixel  bgPix;
	palIndex palAddr;

	rasterIf raster();

	videoTiming timing (
		.VCLK  (VCLK),
		.rstN  (rstN),
		.raster(raster.timing),
		.hSync (hSync),
		.vSync (vSync)
	);

	bgScanline bg (
		.VCLK       (VCLK),
		.rstN       (rstN),
		.raster     (raster.consumer),
		.vramAddrOut(vramAddr),
		.vramData   (vramData),
		.chrAddrOut (chrAddr),
		.chrData    (chrData),
		.pixel      (bgPix)
	);

	planeMixer mixer (
		.bgIn   (bgPix),
		.spIn   (spPixel),
		.palAddr(palAddr)
	);

	colorPalette palette (
		.VCLK   (VCLK),
		.rstN   (rstN),
		.raster (raster.consumer),
		.palAddr(palAddr),
		.wrEn   (palWe),
		.wrAddr (palWrAddr),
		.wrData (palWrData),
		.rgb    (rgb)
	);

endmodule

`default_nettype wire

// File: verilog/colorPalette.sv
// Colour palette RAM and RGB expansion
`timescale 1ns/1ps
`default_nettype none

module colorPalette
	import videoPkg::*;
(
	input  logic       VCLK,
	input  logic       rstN,
	rasterIf.consumer  raster,
	input  palIndex    palAddr,
	input  logic       wrEn,
	input  palIndex    wrAddr,
	input  palEntry    wrData,
	output rgb12       rgb
);

	palEntry    palRam [palDepth];
	palEntry    readQ;
	logic [2:0] blankDly;  // Blank lined up with the pixel pipe
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;

	always_ff @(posedge VCLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < palDepth; i++)
				palRam[i] <= '0;
			readQ    <= '0;
			blankDly <= '0;
		end else begin
			if (wrEn)
				palRam[wrAddr] <= wrData;
			readQ    <= palRam[palAddr];  // Old data on a colliding write
			blankDly <= {blankDly[1:0], raster.hBlank | raster.vBlank};
		end
	end

	// Two bits per channel plus the shared low pair
	assign red   = {readQ[3:2], readQ[1:0]};
	assign green = {readQ[5:4], readQ[1:0]};
	assign blue  = {readQ[7:6], readQ[1:0]};

	assign rgb = blankDly[2] ? '0 : {blue, green, red};

endmodule

`default_nettype wire

// File: verilog/planeMixer.sv
// Background and sprite plane mixer
`timescale 1ns/1ps
`default_nettype none

module planeMixer
	import videoPkg::*;
(
	input  bgPixel  bgIn,
	input  pen      spIn,
	output palIndex palAddr
);

	logic bgOver;    // Priority tile with a visible pen
	logic spOpaque;
	pen   bgPen;

	assign bgPen    = bgIn[3:0];
	assign bgOver   = bgIn[4] && (bgPen != 4'd0);
	assign spOpaque = (spIn != 4'd0);

	// Upper half of the palette is background, lower half sprites
	always_comb begin
		if (bgOver)
			palAddr = {1'b1, bgPen};
		else if (spOpaque)
			palAddr = {1'b0, spIn};
		else
			palAddr = {1'b1, bgPen};  // Includes pen 0 backdrop
	end

endmodule

`default_nettype wire

// File: verilog/bgScanline.sv
// Background tile scanline generator
`timescale 1ns/1ps
`default_nettype none

module bgScanline
	import videoPkg::*;
(
	input  logic       VCLK,
	input  logic       rstN,
	rasterIf.consumer  raster,
	output vramAddr    vramAddrOut,
	input  vramWord    vramData,
	output chrAddr     chrAddrOut,
	input  chrWord     chrData,
	output bgPixel     pixel
);

	rasterPos   posH;
	rasterPos   posV;
	rasterPos   rowHeld;  // Scrolled line, latched once per line
	logic [4:0] attr;     // Priority and colour of the fetched tile
	pen         nib;

	assign posH = raster.h + bgHOffset;
	assign posV = raster.lineStart ? raster.v + bgVOffset : rowHeld;

	// Stage 0, map is 32 by 32 tiles of 8 pixels
	assign vramAddrOut = {posV[7:3], posH[7:3]};

	// Nibble order of the character ROM
	always_comb begin
		case (posH[2:0])
			3'd1:    nib = chrData[7:4];
			3'd2:    nib = chrData[3:0];
			3'd3:    nib = chrData[15:12];
			3'd4:    nib = chrData[11:8];
			3'd5:    nib = chrData[23:20];
			3'd6:    nib = chrData[19:16];
			3'd7:    nib = chrData[31:28];
			default: nib = chrData[27:24];
		endcase
	end

	always_ff @(posedge VCLK or negedge rstN) begin
		if (!rstN) begin
			rowHeld    <= bgVOffset;  // Line 0 scrolled
			chrAddrOut <= '0;
			attr       <= '0;
			pixel      <= '0;
		end else begin
			if (raster.lineStart)
				rowHeld <= posV;
			// Stage 1
			chrAddrOut <= {vramData[10:0], posV[2:0]};
			attr       <= {vramData[11], vramData[15:12]};
			// Stage 2 pairs the ROM word with the older attribute
			// Pen 1 takes the colour field, the board's shadow pen
			pixel <= {attr[4], (nib == 4'd1) ? attr[3:0] : nib};
		end
	end

endmodule

`default_nettype wire

// File: verilog/videoTiming.sv
// Raster timing generator
`timescale 1ns/1ps
`default_nettype none

module videoTiming
	import videoPkg::*;
(
	input  logic     VCLK,
	input  logic     rstN,
	rasterIf.timing  raster,
	output logic     hSync,
	output logic     vSync
);

	rasterPos   hCount;
	rasterPos   vCount;
	rasterPos   vNext;
	timingState state;
	logic       lineEnd;
	logic       lineStartQ;

	assign lineEnd = (hCount == hTotal - 1'b1);
	assign vNext   = (vCount == vTotal - 1'b1) ? '0 : vCount + 1'b1;

	always_ff @(posedge VCLK or negedge rstN) begin
		if (!rstN) begin
			hCount     <= '0;
			vCount     <= '0;
			state      <= activeLines;
			lineStartQ <= 1'b0;
		end else begin
			lineStartQ <= lineEnd;  // High while h reads 0
			if (lineEnd) begin
				hCount <= '0;
				vCount <= vNext;
				// Phase follows the line being entered
				case (state)
					activeLines: if (vNext == vVisible)   state <= frontPorch;
					frontPorch:  if (vNext == vSyncStart) state <= syncLines;
					syncLines:   if (vNext == vSyncEnd)   state <= backPorch;
					backPorch:   if (vNext == '0)         state <= activeLines;
					default:                              state <= activeLines;
				endcase
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	assign raster.h         = hCount;
	assign raster.v         = vCount;
	assign raster.lineStart = lineStartQ;
	assign raster.hBlank    = (hCount >= hVisible);
	assign raster.vBlank    = (state != activeLines);

	assign hSync = (hCount >= hSyncStart) && (hCount < hSyncEnd);
	assign vSync = (state == syncLines);  // Lines 240 to 243

endmodule

`default_nettype wire

// File: verilog/rasterIf.sv
// Raster position bundle
`timescale 1ns/1ps
`default_nettype none

interface rasterIf
	import videoPkg::*;
;
	rasterPos h;
	rasterPos v;
	logic     hBlank;
	logic     vBlank;
	logic     lineStart;  // One cycle, h back at 0

	modport timing (
		output h, v, hBlank, vBlank, lineStart
	);

	modport consumer (
		input h, v, hBlank, vBlank, lineStart
	);

endinterface

`default_nettype wire

// File: verilog/videoPkg.sv
// Video output stage definitions
`default_nettype none

package videoPkg;

	typedef logic [8:0]  rasterPos;  // Pixel or line coordinate
	typedef logic [9:0]  vramAddr;   // Tile row, tile column
	typedef logic [15:0] vramWord;   // Colour, priority, character
	typedef logic [13:0] chrAddr;    // Character number, tile row
	typedef logic [31:0] chrWord;    // Eight packed pens
	typedef logic [3:0]  pen;        // 0 is transparent
	typedef logic [4:0]  bgPixel;    // Priority bit and pen
	typedef logic [4:0]  palIndex;
	typedef logic [7:0]  palEntry;   // BBGGRRxx with shared low bits
	typedef logic [11:0] rgb12;      // Blue, green, red

	// Vertical phase of the frame
	typedef enum logic [1:0] {
		activeLines,
		frontPorch,
		syncLines,
		backPorch
	} timingState;

	// Raster geometry of the board
	localparam rasterPos hTotal     = 9'd384;
	localparam rasterPos vTotal     = 9'd264;
	localparam rasterPos hVisible   = 9'd256;
	localparam rasterPos vVisible   = 9'd224;
	localparam rasterPos hSyncStart = 9'd304;
	localparam rasterPos hSyncEnd   = 9'd336;
	localparam rasterPos vSyncStart = 9'd240;
	localparam rasterPos vSyncEnd   = 9'd244;

	// Fixed background scroll
	localparam rasterPos bgHOffset  = 9'd2;
	localparam rasterPos bgVOffset  = 9'd32;

	localparam int palDepth = 32;

endpackage

`default_nettype wire
